/* spu_config.svh */
`ifndef SPU_CONFIG_SVH
`define SPU_CONFIG_SVH

// --------------------
// data path
// --------------------

// width of one data word
`define SPU_DATA_BITS   8

// immediate field, sized so the instruction word stays 16 bits
`define SPU_IMM_BITS    11

// m_data value after reset or clear
`define SPU_CLEAR_DATA  {`SPU_DATA_BITS{1'b1}}

`endif

/* spu_isa_pkg.sv */
`include "spu_config.svh"

package spu_isa_pkg;

    // --------------------
    // opcodes
    // --------------------

    typedef enum logic [3:0] {
        SPU_OP_AND  = 4'd0,
        SPU_OP_OR   = 4'd1,
        SPU_OP_XOR  = 4'd2,
        SPU_OP_NAND = 4'd3,
        SPU_OP_NOR  = 4'd4,
        SPU_OP_XNOR = 4'd5,
        SPU_OP_ANDN = 4'd6,     // data0 & ~b
        SPU_OP_PASS = 4'd7      // data0 only
    } spu_opcode_e;             // 8..15 reserved, give zero

    typedef enum logic {
        SPU_FMT_REG = 1'b0,     // b from data1
        SPU_FMT_IMM = 1'b1      // b from imm field
    } spu_fmt_e;

    // --------------------
    // instruction layouts
    // --------------------

    typedef struct packed {
        spu_opcode_e opcode;    // [15:12]
        spu_fmt_e    fmt;       // [11]
        logic        invert_a;
        logic        invert_b;
        logic [8:0]  reserved;
    } spu_instr_reg_t;

    typedef struct packed {
        spu_opcode_e                opcode; // same place as register format
        spu_fmt_e                   fmt;
        logic [`SPU_IMM_BITS-1:0]   imm;
    } spu_instr_imm_t;

    // one 16-bit word, read either way
    typedef union packed {
        spu_instr_reg_t rfmt;
        spu_instr_imm_t ifmt;
    } spu_instr_u;

endpackage

/* spu_data_pkg.sv */
`include "spu_config.svh"

package spu_data_pkg;

    import spu_isa_pkg::*;

    typedef logic [`SPU_DATA_BITS-1:0] spu_data_t;

    // --------------------
    // stage bundles
    // --------------------

    // unit input, sampled every enabled cycle
    typedef struct packed {
        spu_data_t  data0;
        spu_data_t  data1;
        spu_instr_u instr;
        logic       clear;
        logic       valid;
    } spu_op_in_t;

    // decode -> logic
    typedef struct packed {
        spu_data_t   a;
        spu_data_t   b;
        spu_opcode_e opcode;
        logic        clear;
        logic        valid;
    } spu_operands_t;

    // logic -> result
    typedef struct packed {
        spu_data_t result;
        logic      clear;
        logic      valid;
    } spu_result_t;

endpackage

/* spu_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_op_decode
    import spu_isa_pkg::*;
    import spu_data_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          cke,
    input  spu_op_in_t    s_op,
    output spu_operands_t operands
);

    // --------------------
    // operand select
    // --------------------

    spu_fmt_e    fmt;
    spu_opcode_e opcode;
    spu_data_t   op_a;
    spu_data_t   op_b;

    assign fmt    = s_op.instr.rfmt.fmt;       // same bit in both layouts
    assign opcode = s_op.instr.rfmt.opcode;

    always_comb begin
        op_a = s_op.data0;
        op_b = s_op.data1;
        if (fmt == SPU_FMT_IMM) begin
            op_b = spu_data_t'(s_op.instr.ifmt.imm);  // zero-extend or truncate
        end else begin
            // inversion bits only exist in register format
            if (s_op.instr.rfmt.invert_a) begin
                op_a = ~s_op.data0;
            end
            if (s_op.instr.rfmt.invert_b) begin
                op_b = ~s_op.data1;
            end
        end
    end

    // --------------------
    // stage register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            operands.clear <= 1'b0;
            operands.valid <= 1'b0;
        end else if (cke) begin
            operands.clear <= s_op.clear;
            operands.valid <= s_op.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            operands.a      <= op_a;
            operands.b      <= op_b;
            operands.opcode <= opcode;
        end
    end

endmodule

`default_nettype wire

/* spu_op_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_op_logic
    import spu_isa_pkg::*;
    import spu_data_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          cke,
    input  spu_operands_t operands,
    output spu_result_t   result
);

    // --------------------
    // operation table
    // --------------------

    spu_data_t res;

    always_comb begin
        case (operands.opcode)
            SPU_OP_AND:  res = operands.a & operands.b;
            SPU_OP_OR:   res = operands.a | operands.b;
            SPU_OP_XOR:  res = operands.a ^ operands.b;
            SPU_OP_NAND: res = ~(operands.a & operands.b);
            SPU_OP_NOR:  res = ~(operands.a | operands.b);
            SPU_OP_XNOR: res = ~(operands.a ^ operands.b);
            SPU_OP_ANDN: res = operands.a & ~operands.b;
            SPU_OP_PASS: res = operands.a;     // b ignored
            default:     res = '0;             // reserved codes
        endcase
    end

    // --------------------
    // stage register
    // --------------------

    // flags travel with the word
    always_ff @(posedge clk) begin
        if (reset) begin
            result.clear <= 1'b0;
            result.valid <= 1'b0;
        end else if (cke) begin
            result.clear <= operands.clear;
            result.valid <= operands.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            result.result <= res;
        end
    end

endmodule

`default_nettype wire

/* spu_op_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spu_config.svh"

module spu_op_result
    import spu_data_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,
    input  spu_result_t result,
    output spu_data_t   m_data
);

    // --------------------
    // output register
    // --------------------

    // m_data is a held level, no output valid
    always_ff @(posedge clk) begin
        if (reset) begin
            m_data <= `SPU_CLEAR_DATA;
        end else if (cke) begin
            if (result.clear) begin
                m_data <= `SPU_CLEAR_DATA;     // clear wins over valid
            end else if (result.valid) begin
                m_data <= result.result;
            end
            // neither flag: keep last value
        end
    end

endmodule

`default_nettype wire

/* spu_op_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_op_unit
    import spu_data_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cke,
    input  spu_op_in_t s_op,
    output spu_data_t  m_data
);

    spu_operands_t operands;    // decode -> logic
    spu_result_t   result;      // logic -> result

    // --------------------
    // pipeline
    // --------------------

    spu_op_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .s_op     (s_op),
        .operands (operands)
    );

    spu_op_logic u_logic (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .operands (operands),
        .result   (result)
    );

    spu_op_result u_result (
        .clk    (clk),
        .reset  (reset),
        .cke    (cke),
        .result (result),
        .m_data (m_data)
    );

endmodule

`default_nettype wire

/* spu_op_unit_assertions.sv */
`timescale 1ns/1ps

`include "spu_config.svh"

module spu_op_unit_assertions
    import spu_data_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          cke,
    input spu_operands_t operands,
    input spu_result_t   result,
    input spu_data_t     m_data
);

    // --------------------
    // reset and clear
    // --------------------

    a_reset_clear: assert property (@(posedge clk) reset |=> m_data == `SPU_CLEAR_DATA)
        else $error("m_data is not the clear value one cycle after reset");

    a_result_clear: assert property (@(posedge clk)
        (!reset && cke && result.clear) |=> m_data == `SPU_CLEAR_DATA)
        else $error("clear item at the result stage did not load the clear value");

    // --------------------
    // stall
    // --------------------

    a_stall_hold: assert property (@(posedge clk)
        (!reset && !cke) |=> ((operands === $past(operands)) &&
                              (result === $past(result)) &&
                              (m_data === $past(m_data))))
        else $error("a stage register changed during a cycle with cke low");

endmodule

bind spu_op_unit spu_op_unit_assertions u_assertions (
    .clk      (clk),
    .reset    (reset),
    .cke      (cke),
    .operands (operands),
    .result   (result),
    .m_data   (m_data)
);

/* tb_spu_op_unit.sv */
`timescale 1ns/1ps

`include "spu_config.svh"

module tb_spu_op_unit
    import spu_isa_pkg::*;
    import spu_data_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       cke;
    spu_op_in_t s_op;
    spu_data_t  m_data;

    int         seed;
    spu_data_t  model_q[$];     // expected m_data, oldest first
    spu_data_t  model_last;     // newest expected value
    spu_data_t  last_checked;   // value seen after the last edge

    spu_op_unit u_spu_op_unit (
        .clk    (clk),
        .reset  (reset),
        .cke    (cke),
        .s_op   (s_op),
        .m_data (m_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // reporting
    // --------------------

    task automatic fail_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input spu_data_t expected,
                              input spu_data_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic spu_data_t rand_data();
        return spu_data_t'($random(seed));
    endfunction

    function automatic spu_data_t pattern(input int p);
        if (p == 0) begin
            return '0;
        end
        if (p == 1) begin
            return '1;
        end
        return rand_data();
    endfunction

    function automatic spu_instr_u make_reg(input spu_opcode_e op, input logic inv_a,
                                            input logic inv_b);
        spu_instr_u w;
        w.rfmt.opcode   = op;
        w.rfmt.fmt      = SPU_FMT_REG;
        w.rfmt.invert_a = inv_a;
        w.rfmt.invert_b = inv_b;
        w.rfmt.reserved = 9'($random(seed));   // must not matter
        return w;
    endfunction

    function automatic spu_instr_u make_imm(input spu_opcode_e op,
                                            input logic [`SPU_IMM_BITS-1:0] imm);
        spu_instr_u w;
        w.ifmt.opcode = op;
        w.ifmt.fmt    = SPU_FMT_IMM;
        w.ifmt.imm    = imm;
        return w;
    endfunction

    function automatic spu_op_in_t make_in(input spu_data_t d0, input spu_data_t d1,
                                           input spu_instr_u instr, input logic clear,
                                           input logic valid);
        spu_op_in_t item;
        item.data0 = d0;
        item.data1 = d1;
        item.instr = instr;
        item.clear = clear;
        item.valid = valid;
        return item;
    endfunction

    // reference model, works on the raw 16-bit instruction word
    function automatic spu_data_t model_result(input spu_op_in_t item, input spu_data_t last);
        logic [15:0] w;
        spu_data_t   a;
        spu_data_t   b;
        spu_data_t   r;
        w = item.instr;
        if (item.clear) begin
            return `SPU_CLEAR_DATA;
        end
        if (!item.valid) begin
            return last;
        end
        a = item.data0;
        b = item.data1;
        if (w[11]) begin
            b = spu_data_t'(w[`SPU_IMM_BITS-1:0]);  // immediate, no inversion
        end else begin
            if (w[10]) begin
                a = ~a;
            end
            if (w[9]) begin
                b = ~b;
            end
        end
        case (w[15:12])
            4'd0:    r = a & b;
            4'd1:    r = a | b;
            4'd2:    r = a ^ b;
            4'd3:    r = ~(a & b);
            4'd4:    r = ~(a | b);
            4'd5:    r = ~(a ^ b);
            4'd6:    r = a & ~b;
            4'd7:    r = a;
            default: r = '0;
        endcase
        return r;
    endfunction

    // one cycle, driven at the falling edge, checked at the next one
    task automatic step(input spu_op_in_t item, input logic en);
        spu_data_t expected;
        s_op = item;
        cke  = en;
        if (en) begin
            model_last = model_result(item, model_last);
            model_q.push_back(model_last);
        end
        @(posedge clk);
        @(negedge clk);
        if (en) begin
            expected = model_q.pop_front();
            check_data("m_data", expected, m_data);
        end else begin
            check_data("m_data", last_checked, m_data);   // stalled, must hold
        end
        last_checked = m_data;
    endtask

    task automatic flush();
        for (int i = 0; i < 3; i++) begin
            step(make_in(rand_data(), rand_data(), make_reg(SPU_OP_AND, 1'b0, 1'b0),
                         1'b0, 1'b0), 1'b1);
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (reset) begin
            if (cycles == 10) begin
                fail_run("reset was not released");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_after_reset();
        check_data("m_data", `SPU_CLEAR_DATA, m_data);
        for (int i = 0; i < 5; i++) begin
            step(make_in(rand_data(), rand_data(), spu_instr_u'(16'($random(seed))),
                         1'b0, 1'b0), 1'b1);
        end
    endtask

    task automatic test_reg_sweep();
        spu_instr_u instr;
        for (int op = 0; op < 16; op++) begin
            for (int inv = 0; inv < 4; inv++) begin
                for (int p = 0; p < 9; p++) begin
                    instr = make_reg(spu_opcode_e'(op[3:0]), inv[1], inv[0]);
                    step(make_in(pattern(p / 3), pattern(p % 3), instr, 1'b0, 1'b1), 1'b1);
                end
            end
        end
        flush();
    endtask

    task automatic test_imm();
        logic [`SPU_IMM_BITS-1:0] imm;
        for (int op = 0; op < 16; op++) begin
            for (int i = 0; i < 6; i++) begin
                imm = `SPU_IMM_BITS'($random(seed));
                if (i % 2 == 0) begin
                    imm[10:9] = 2'b11;      // invert bits of register format
                end
                step(make_in(rand_data(), rand_data(), make_imm(spu_opcode_e'(op[3:0]), imm),
                             1'b0, 1'b1), 1'b1);
            end
        end
        step(make_in('1, '0, make_imm(SPU_OP_XOR, '1), 1'b0, 1'b1), 1'b1);
        step(make_in('1, '1, make_imm(SPU_OP_AND, '0), 1'b0, 1'b1), 1'b1);
        flush();
    endtask

    task automatic test_clear_hold();
        step(make_in(8'h5a, 8'h0f, make_reg(SPU_OP_AND, 1'b0, 1'b0), 1'b0, 1'b1), 1'b1);
        step(make_in(8'h12, 8'h34, make_reg(SPU_OP_OR, 1'b0, 1'b0), 1'b1, 1'b1), 1'b1);
        step(make_in(8'h3c, 8'h00, make_reg(SPU_OP_PASS, 1'b0, 1'b0), 1'b0, 1'b1), 1'b1);
        step(make_in(rand_data(), rand_data(), make_reg(SPU_OP_NOR, 1'b1, 1'b1),
                     1'b0, 1'b0), 1'b1);
        step(make_in(rand_data(), rand_data(), make_reg(SPU_OP_XOR, 1'b0, 1'b1),
                     1'b0, 1'b0), 1'b1);
        step(make_in(8'h00, 8'h00, make_reg(SPU_OP_AND, 1'b0, 1'b0), 1'b1, 1'b0), 1'b1);
        flush();
        check_data("m_data", `SPU_CLEAR_DATA, m_data);
    endtask

    task automatic test_stalls();
        logic en;
        for (int i = 0; i < 120; i++) begin
            en = (($random(seed) & 3) != 0);
            step(make_in(rand_data(), rand_data(), spu_instr_u'(16'($random(seed))),
                         (($random(seed) & 15) == 0), 1'b1), en);
        end
        flush();
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        seed  = 77392;
        reset = 1'b1;
        cke   = 1'b1;
        s_op  = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        cke   = 1'b0;
        wait_reset_done();
        model_q.delete();
        model_q.push_back(`SPU_CLEAR_DATA);     // stage registers come out of reset empty
        model_q.push_back(`SPU_CLEAR_DATA);
        model_last   = `SPU_CLEAR_DATA;
        last_checked = `SPU_CLEAR_DATA;

        test_after_reset();
        test_reg_sweep();
        test_imm();
        test_clear_hold();
        test_stalls();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
spu_isa_pkg.sv
spu_data_pkg.sv
spu_op_decode.sv
spu_op_logic.sv
spu_op_result.sv
spu_op_unit.sv
spu_op_unit_assertions.sv
tb_spu_op_unit.sv

/* Makefile */
# Verilator build for the spu logic-operation unit

VERILATOR ?= verilator
TOP       ?= tb_spu_op_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
